/* src/isa_pkg.sv */
package isa_pkg;

    typedef logic [4:0] reg_idx_t;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,   // Decoded further by funct
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    // One instruction word seen through its three encodings
    typedef union packed {
        struct packed {
            opcode_e    opcode;
            reg_idx_t   rs;
            reg_idx_t   rt;
            reg_idx_t   rd;
            logic [4:0] shamt;
            funct_e     funct;
        } r_fmt;
        struct packed {
            opcode_e     opcode;
            reg_idx_t    rs;
            reg_idx_t    rt;
            logic [15:0] imm;
        } i_fmt;
        struct packed {
            opcode_e     opcode;
            logic [25:0] index;     // Word index inside the current 256 MB region
        } j_fmt;
    } instr_u;

    localparam reg_idx_t LINK_REG = 5'd31;     // Return address register

endpackage

/* src/pipe_pkg.sv */
package pipe_pkg;

    localparam int WORD_W = 32;     // Datapath word carried between stages

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4,
        ALU_SLL = 4'd5,
        ALU_LUI = 4'd6
    } alu_op_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;   // Second operand is the immediate
        logic    reg_dst_rd;    // Destination from rd
        logic    link;          // Result is PC+8
    } ex_ctrl_t;

    typedef struct packed {
        logic mem_read;
        logic mem_write;
        logic branch;
        logic branch_ne;        // BNE when set
    } mem_ctrl_t;

    typedef struct packed {
        logic reg_write;
        logic mem_to_reg;
    } wb_ctrl_t;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] pc;
        logic [WORD_W-1:0] rs_val;
        logic [WORD_W-1:0] rt_val;
        isa_pkg::reg_idx_t rs;
        isa_pkg::reg_idx_t rt;
        isa_pkg::reg_idx_t dest;
        logic [WORD_W-1:0] imm;     // Already extended
        logic [4:0]        shamt;
        ex_ctrl_t          ex;
        mem_ctrl_t         mem;
        wb_ctrl_t          wb;
    } id_ex_t;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] alu_res;     // Also the memory byte address
        logic [WORD_W-1:0] store_data;
        isa_pkg::reg_idx_t dest;
        mem_ctrl_t         mem;
        wb_ctrl_t          wb;
    } ex_res_t;

    typedef struct packed {
        logic              valid;
        isa_pkg::reg_idx_t dest;
        logic [WORD_W-1:0] data;
    } wb_t;

endpackage

/* src/reg_file.sv */
module reg_file #(
    parameter int DATA_W = 32
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  isa_pkg::reg_idx_t i_rd_addr_a,
    input  isa_pkg::reg_idx_t i_rd_addr_b,
    input  pipe_pkg::wb_t     i_wb,
    output logic [DATA_W-1:0] o_rd_data_a,
    output logic [DATA_W-1:0] o_rd_data_b
);
    import isa_pkg::*;

    localparam int NUM_REGS = 2 ** $bits(reg_idx_t);

    logic [DATA_W-1:0] regs [NUM_REGS];
    logic              wr_en;

    assign wr_en = i_wb.valid && (i_wb.dest != '0);    // r0 never written

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
        begin
            regs[i_wb.dest] <= i_wb.data;
        end
    end

    // Write-through lets decode see the value retiring this cycle
    assign o_rd_data_a = (wr_en && i_wb.dest == i_rd_addr_a) ? i_wb.data : regs[i_rd_addr_a];
    assign o_rd_data_b = (wr_en && i_wb.dest == i_rd_addr_b) ? i_wb.data : regs[i_rd_addr_b];

    a_r0_reads_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        ((i_rd_addr_a != '0) || (o_rd_data_a == '0))
        && ((i_rd_addr_b != '0) || (o_rd_data_b == '0)));

endmodule

/* src/decode_stage.sv */
module decode_stage #(
    parameter int DATA_W = 32
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_instr_valid,
    input  isa_pkg::instr_u   i_instr,
    input  logic [DATA_W-1:0] i_pc,
    output isa_pkg::reg_idx_t o_rd_addr_a,
    output isa_pkg::reg_idx_t o_rd_addr_b,
    input  logic [DATA_W-1:0] i_rd_data_a,
    input  logic [DATA_W-1:0] i_rd_data_b,
    input  isa_pkg::reg_idx_t i_ex_dest,
    input  logic              i_ex_load,
    input  logic              i_ex_writes,
    output logic              o_stall,
    output logic              o_jump,
    output logic [DATA_W-1:0] o_jump_target,
    output pipe_pkg::id_ex_t  o_id_ex
);
    import isa_pkg::*;
    import pipe_pkg::*;

    opcode_e           opcode;
    reg_idx_t          rs;
    reg_idx_t          rt;
    reg_idx_t          dest;
    logic [DATA_W-1:0] imm_ext;
    ex_ctrl_t          ex_ctrl;
    mem_ctrl_t         mem_ctrl;
    wb_ctrl_t          wb_ctrl;
    logic              uses_rs;
    logic              uses_rt;
    logic              imm_zero;
    logic              is_j;
    logic              is_jr;
    logic              ex_hit_rs;
    logic              ex_hit_rt;
    logic              accept;

    assign opcode      = i_instr.r_fmt.opcode;
    assign rs          = i_instr.i_fmt.rs;     // Same bits in R and I formats
    assign rt          = i_instr.i_fmt.rt;
    assign o_rd_addr_a = rs;
    assign o_rd_addr_b = rt;

    always_comb
    begin
        ex_ctrl  = '0;
        mem_ctrl = '0;
        wb_ctrl  = '0;
        uses_rs  = 1'b1;
        uses_rt  = 1'b0;
        imm_zero = 1'b0;
        is_j     = 1'b0;
        is_jr    = 1'b0;
        case (opcode)
            OP_RTYPE:
            begin
                ex_ctrl.reg_dst_rd = 1'b1;
                wb_ctrl.reg_write  = 1'b1;
                uses_rt            = 1'b1;
                case (i_instr.r_fmt.funct)
                    FN_ADDU: ex_ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ex_ctrl.alu_op = ALU_SUB;
                    FN_AND:  ex_ctrl.alu_op = ALU_AND;
                    FN_OR:   ex_ctrl.alu_op = ALU_OR;
                    FN_SLT:  ex_ctrl.alu_op = ALU_SLT;
                    FN_SLL:
                    begin
                        ex_ctrl.alu_op = ALU_SLL;
                        uses_rs        = 1'b0;
                    end
                    FN_JR, FN_JALR:
                    begin
                        is_jr             = 1'b1;
                        uses_rt           = 1'b0;
                        ex_ctrl.link      = (i_instr.r_fmt.funct == FN_JALR);
                        wb_ctrl.reg_write = (i_instr.r_fmt.funct == FN_JALR);
                    end
                    default: wb_ctrl.reg_write = 1'b0;     // Unsupported funct runs as a NOP
                endcase
            end
            OP_ADDIU, OP_ANDI, OP_ORI:
            begin
                ex_ctrl.alu_src_imm = 1'b1;
                wb_ctrl.reg_write   = 1'b1;
                imm_zero            = (opcode != OP_ADDIU);
                if (opcode == OP_ANDI)
                    ex_ctrl.alu_op = ALU_AND;
                else if (opcode == OP_ORI)
                    ex_ctrl.alu_op = ALU_OR;
            end
            OP_LUI:
            begin
                ex_ctrl.alu_op      = ALU_LUI;
                ex_ctrl.alu_src_imm = 1'b1;
                wb_ctrl.reg_write   = 1'b1;
                uses_rs             = 1'b0;
            end
            OP_LW:
            begin
                ex_ctrl.alu_src_imm = 1'b1;
                mem_ctrl.mem_read   = 1'b1;
                wb_ctrl             = '{reg_write: 1'b1, mem_to_reg: 1'b1};
            end
            OP_SW:
            begin
                ex_ctrl.alu_src_imm = 1'b1;
                mem_ctrl.mem_write  = 1'b1;
                uses_rt             = 1'b1;
            end
            OP_BEQ, OP_BNE:
            begin
                mem_ctrl.branch    = 1'b1;
                mem_ctrl.branch_ne = (opcode == OP_BNE);
                uses_rt            = 1'b1;
            end
            OP_J, OP_JAL:
            begin
                is_j              = 1'b1;
                uses_rs           = 1'b0;
                ex_ctrl.link      = (opcode == OP_JAL);
                wb_ctrl.reg_write = (opcode == OP_JAL);
            end
            default: uses_rs = 1'b0;
        endcase
    end

    always_comb
    begin
        if (ex_ctrl.reg_dst_rd)
            dest = i_instr.r_fmt.rd;    // R-type and JALR
        else if (ex_ctrl.link)
            dest = LINK_REG;            // JAL
        else
            dest = rt;
    end

    assign imm_ext = imm_zero ? {{(DATA_W-16){1'b0}}, i_instr.i_fmt.imm}
                              : {{(DATA_W-16){i_instr.i_fmt.imm[15]}}, i_instr.i_fmt.imm};

    // Only the instruction in execute can be ahead of the register file
    assign ex_hit_rs = uses_rs && (i_ex_dest != '0) && (i_ex_dest == rs);
    assign ex_hit_rt = uses_rt && (i_ex_dest != '0) && (i_ex_dest == rt);
    assign o_stall   = i_instr_valid && ((i_ex_load && (ex_hit_rs || ex_hit_rt))
                                        || (is_jr && i_ex_writes && ex_hit_rs));
    assign accept    = i_instr_valid && !o_stall;

    assign o_jump        = accept && (is_j || is_jr);
    assign o_jump_target = is_jr ? i_rd_data_a
                                 : {i_pc[DATA_W-1:DATA_W-4], i_instr.j_fmt.index, 2'b00};

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            o_id_ex.valid <= 1'b0;
            o_id_ex.ex    <= '0;
            o_id_ex.mem   <= '0;
            o_id_ex.wb    <= '0;
        end
        else
        begin
            o_id_ex.valid  <= accept;
            o_id_ex.ex     <= accept ? ex_ctrl : '0;     // Bubble when stalled or idle
            o_id_ex.mem    <= accept ? mem_ctrl : '0;
            o_id_ex.wb     <= accept ? wb_ctrl : '0;
            o_id_ex.pc     <= i_pc;
            o_id_ex.rs_val <= i_rd_data_a;
            o_id_ex.rt_val <= i_rd_data_b;
            o_id_ex.rs     <= rs;
            o_id_ex.rt     <= rt;
            o_id_ex.dest   <= dest;
            o_id_ex.imm    <= imm_ext;
            o_id_ex.shamt  <= i_instr.r_fmt.shamt;
        end
    end

    // A stall needs an instruction and clears once the bubble is in execute
    a_stall_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_stall |-> i_instr_valid ##1 !o_stall);

endmodule

/* src/execute_stage.sv */
module execute_stage #(
    parameter int DATA_W = 32
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  pipe_pkg::id_ex_t  i_id_ex,
    input  pipe_pkg::wb_t     i_wb,
    output isa_pkg::reg_idx_t o_ex_dest,
    output logic              o_ex_load,
    output logic              o_ex_writes,
    output logic              o_branch_taken,
    output logic [DATA_W-1:0] o_branch_target,
    output pipe_pkg::ex_res_t o_ex_res
);
    import pipe_pkg::*;

    logic              fwd_a;
    logic              fwd_b;
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] alu_b;
    logic [DATA_W-1:0] alu_res;
    logic [DATA_W-1:0] result;

    // Result stage holds the next older instruction
    assign fwd_a = i_wb.valid && (i_wb.dest != '0) && (i_wb.dest == i_id_ex.rs);
    assign fwd_b = i_wb.valid && (i_wb.dest != '0) && (i_wb.dest == i_id_ex.rt);
    assign op_a  = fwd_a ? i_wb.data : i_id_ex.rs_val;
    assign op_b  = fwd_b ? i_wb.data : i_id_ex.rt_val;
    assign alu_b = i_id_ex.ex.alu_src_imm ? i_id_ex.imm : op_b;

    always_comb
    begin
        case (i_id_ex.ex.alu_op)
            ALU_ADD: alu_res = op_a + alu_b;
            ALU_SUB: alu_res = op_a - alu_b;
            ALU_AND: alu_res = op_a & alu_b;
            ALU_OR:  alu_res = op_a | alu_b;
            ALU_SLT: alu_res = {{(DATA_W-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            ALU_SLL: alu_res = op_b << i_id_ex.shamt;
            ALU_LUI: alu_res = alu_b << 16;
            default: alu_res = '0;
        endcase
    end

    assign result = i_id_ex.ex.link ? i_id_ex.pc + DATA_W'(8) : alu_res;    // Skip the delay slot

    assign o_branch_taken  = i_id_ex.valid && i_id_ex.mem.branch
                             && ((op_a == op_b) != i_id_ex.mem.branch_ne);
    assign o_branch_target = i_id_ex.pc + DATA_W'(4) + (i_id_ex.imm << 2);

    // Seen by the hazard check in decode
    assign o_ex_dest   = i_id_ex.dest;
    assign o_ex_load   = i_id_ex.valid && i_id_ex.mem.mem_read;
    assign o_ex_writes = i_id_ex.valid && i_id_ex.wb.reg_write;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            o_ex_res.valid <= 1'b0;
            o_ex_res.mem   <= '0;
            o_ex_res.wb    <= '0;
        end
        else
        begin
            o_ex_res.valid      <= i_id_ex.valid;
            o_ex_res.mem        <= i_id_ex.mem;
            o_ex_res.wb         <= i_id_ex.wb;
            o_ex_res.alu_res    <= result;
            o_ex_res.store_data <= op_b;
            o_ex_res.dest       <= i_id_ex.dest;
        end
    end

    a_alu_op_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_id_ex.valid |-> i_id_ex.ex.alu_op inside
            {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL, ALU_LUI});

endmodule

/* src/result_stage.sv */
module result_stage #(
    parameter int DATA_W     = 32,
    parameter int DMEM_DEPTH = 64
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  pipe_pkg::ex_res_t i_ex_res,
    output pipe_pkg::wb_t     o_wb
);
    localparam int ADDR_W = $clog2(DMEM_DEPTH);

    logic [DATA_W-1:0] dmem [DMEM_DEPTH];
    logic [ADDR_W-1:0] word_idx;
    logic [DATA_W-1:0] load_data;

    assign word_idx  = i_ex_res.alu_res[ADDR_W+1:2];   // Byte address to word index
    assign load_data = dmem[word_idx];                 // Async read

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < DMEM_DEPTH; i++)
                dmem[i] <= '0;
        end
        else if (i_ex_res.valid && i_ex_res.mem.mem_write)
        begin
            dmem[word_idx] <= i_ex_res.store_data;
        end
    end

    assign o_wb.valid = i_ex_res.valid && i_ex_res.wb.reg_write;
    assign o_wb.dest  = i_ex_res.dest;
    assign o_wb.data  = i_ex_res.wb.mem_to_reg ? load_data : i_ex_res.alu_res;

    a_mem_rw_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_ex_res.valid |-> !(i_ex_res.mem.mem_read && i_ex_res.mem.mem_write));

endmodule

/* src/core_top.sv */
module core_top #(
    parameter int DATA_W     = 32,
    parameter int DMEM_DEPTH = 64
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_instr_valid,
    input  logic [31:0]       i_instr,
    input  logic [DATA_W-1:0] i_pc,
    output logic              o_stall,
    output logic              o_jump,
    output logic [DATA_W-1:0] o_jump_target,
    output logic              o_branch_taken,
    output logic [DATA_W-1:0] o_branch_target,
    output logic              o_wb_valid,
    output isa_pkg::reg_idx_t o_wb_reg,
    output logic [DATA_W-1:0] o_wb_data
);
    import isa_pkg::*;
    import pipe_pkg::*;

    id_ex_t            id_ex;
    ex_res_t           ex_res;
    wb_t               wb;
    reg_idx_t          rd_addr_a;
    reg_idx_t          rd_addr_b;
    reg_idx_t          ex_dest;
    logic [DATA_W-1:0] rd_data_a;
    logic [DATA_W-1:0] rd_data_b;
    logic              ex_load;
    logic              ex_writes;

    decode_stage #(
        .DATA_W         (DATA_W)
    ) u_decode (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_instr_valid  (i_instr_valid),
        .i_instr        (i_instr),
        .i_pc           (i_pc),
        .o_rd_addr_a    (rd_addr_a),
        .o_rd_addr_b    (rd_addr_b),
        .i_rd_data_a    (rd_data_a),
        .i_rd_data_b    (rd_data_b),
        .i_ex_dest      (ex_dest),
        .i_ex_load      (ex_load),
        .i_ex_writes    (ex_writes),
        .o_stall        (o_stall),
        .o_jump         (o_jump),
        .o_jump_target  (o_jump_target),
        .o_id_ex        (id_ex)
    );

    reg_file #(
        .DATA_W         (DATA_W)
    ) u_reg_file (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_rd_addr_a    (rd_addr_a),
        .i_rd_addr_b    (rd_addr_b),
        .i_wb           (wb),
        .o_rd_data_a    (rd_data_a),
        .o_rd_data_b    (rd_data_b)
    );

    execute_stage #(
        .DATA_W         (DATA_W)
    ) u_execute (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_id_ex        (id_ex),
        .i_wb           (wb),
        .o_ex_dest      (ex_dest),
        .o_ex_load      (ex_load),
        .o_ex_writes    (ex_writes),
        .o_branch_taken (o_branch_taken),
        .o_branch_target(o_branch_target),
        .o_ex_res       (ex_res)
    );

    result_stage #(
        .DATA_W         (DATA_W),
        .DMEM_DEPTH     (DMEM_DEPTH)
    ) u_result (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_ex_res       (ex_res),
        .o_wb           (wb)
    );

    assign o_wb_valid = wb.valid;
    assign o_wb_reg   = wb.dest;
    assign o_wb_data  = wb.data;

endmodule

/* test/clk_gen.sv */
module clk_gen #(
    parameter int RESET_CYCLES = 5
) (
    output logic o_clk,
    output logic o_rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;      // 10 ns period
    end

    initial
    begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);               // Release between active edges
        o_rst_n = 1'b1;
    end

endmodule

/* test/tb_core.sv */
module tb_core;
    timeunit 1ns;
    timeprecision 1ps;

    import isa_pkg::*;

    localparam int REC_WORDS = 7;       // Words per golden record
    localparam int MAX_RECS  = 64;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        stall;
    logic        jump;
    logic [31:0] jump_target;
    logic        branch_taken;
    logic [31:0] branch_target;
    logic        wb_valid;
    reg_idx_t    wb_reg;
    logic [31:0] wb_data;

    logic [31:0] golden [REC_WORDS*MAX_RECS];
    logic [63:0] exp_wb[$];
    logic [63:0] obs_wb[$];
    logic [63:0] exp_jump[$];
    logic [63:0] obs_jump[$];
    logic [63:0] exp_branch[$];
    logic [63:0] obs_branch[$];
    logic [15:0] lfsr;
    string       cur_test;
    int          errors   = 0;
    int          checks   = 0;
    int          n_tests  = 0;
    int          n_failed = 0;
    int          n_instr  = 0;
    int          cycles   = 0;
    int          limit    = 0;

    clk_gen #(
        .RESET_CYCLES   (5)
    ) u_clk_gen (
        .o_clk          (clk),
        .o_rst_n        (rst_n)
    );

    core_top #(
        .DATA_W         (32),
        .DMEM_DEPTH     (64)
    ) dut0 (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_instr_valid  (instr_valid),
        .i_instr        (instr),
        .i_pc           (pc),
        .o_stall        (stall),
        .o_jump         (jump),
        .o_jump_target  (jump_target),
        .o_branch_taken (branch_taken),
        .o_branch_target(branch_target),
        .o_wb_valid     (wb_valid),
        .o_wb_reg       (wb_reg),
        .o_wb_data      (wb_data)
    );

    always @(posedge clk)
        cycles <= cycles + 1;

    // Writeback and branch pulses only depend on pipeline registers
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (wb_valid)
                obs_wb.push_back({27'd0, wb_reg, wb_data});
            if (branch_taken)
                obs_branch.push_back({32'd0, branch_target});
        end
    end

    function automatic logic [15:0] galois_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);     // Taps 16,14,13,11
    endfunction

    task automatic draw_bit(output logic b);
        b    = lfsr[0];
        lfsr = galois_step(lfsr);
    endtask

    function automatic string test_name(input int id);
        case (id)
            1:       return "alu_ops";
            2:       return "forwarding";
            3:       return "load_use";
            4:       return "jumps";
            5:       return "branches";
            6:       return "r0_writes";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            $display("Error %s: %s expected %h actual %h", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_events(input string what, input logic has_dest,
                                  input logic [63:0] exp_q[$], input logic [63:0] obs_q[$]);
        int n;
        n = (exp_q.size() > obs_q.size()) ? exp_q.size() : obs_q.size();
        for (int i = 0; i < n; i++)
        begin
            if (i >= obs_q.size())
            begin
                $display("%s: expected %s number %0d never appeared", cur_test, what, i);
                checks++;
                errors++;
            end
            else if (i >= exp_q.size())
            begin
                $display("%s: an unexpected %s appeared as number %0d", cur_test, what, i);
                checks++;
                errors++;
            end
            else
            begin
                if (has_dest)
                    check_value($sformatf("%s %0d dest", what, i), exp_q[i][63:32],
                                obs_q[i][63:32]);
                check_value($sformatf("%s %0d value", what, i), exp_q[i][31:0], obs_q[i][31:0]);
            end
        end
    endtask

    // One word, with an optional idle cycle before it, held while stalled
    task automatic drive_instr(input logic [31:0] at_pc, input logic [31:0] word,
                               input logic adjacent_stall);
        logic   b0;
        logic   b1;
        logic   idle;
        int     stalls;
        instr_u decoded;
        draw_bit(b0);
        draw_bit(b1);
        idle = b0 & b1;
        if (idle)
        begin
            instr_valid = 1'b0;
            @(negedge clk);
        end
        decoded     = word;
        instr_valid = 1'b1;
        instr       = word;
        pc          = at_pc;
        stalls      = 0;
        #1;
        while (stall)
        begin
            stalls++;
            @(negedge clk);             // Same word stays on the inputs
            #1;
        end
        if (jump)
            obs_jump.push_back({32'd0, jump_target});
        @(negedge clk);
        check_value($sformatf("stall cycles at pc %h (%s)", at_pc, decoded.r_fmt.opcode.name()),
                    (adjacent_stall && !idle) ? 32'd1 : 32'd0, stalls);
    endtask

    task automatic drain_pipeline;
        instr_valid = 1'b0;
        while (obs_wb.size() < exp_wb.size() || obs_branch.size() < exp_branch.size())
            @(negedge clk);
        repeat (2) @(negedge clk);      // Pipeline depth, catches stray pulses
    endtask

    initial
    begin
        int          idx;
        int          base;
        int          test_id;
        int          errors_before;
        logic [31:0] flags;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        lfsr        = 16'd40;
        for (int i = 0; i < REC_WORDS*MAX_RECS; i++)
            golden[i] = '0;
        $readmemh("test/core_golden.txt", golden);
        while (n_instr < MAX_RECS && golden[n_instr*REC_WORDS] != 0)
            n_instr++;
        limit = 3*n_instr + 50;
        if (n_instr == 0)
        begin
            $display("The golden file holds no instructions");
            errors++;
        end

        @(posedge rst_n);
        @(negedge clk);
        idx = 0;
        while (idx < n_instr)
        begin
            test_id       = golden[idx*REC_WORDS];
            cur_test      = test_name(test_id);
            errors_before = errors;
            while (idx < n_instr && golden[idx*REC_WORDS] == test_id)
            begin
                base  = idx*REC_WORDS;
                flags = golden[base+1];
                if (flags[1])
                    exp_wb.push_back({golden[base+4], golden[base+5]});
                if (flags[2])
                    exp_jump.push_back({32'd0, golden[base+6]});
                if (flags[3])
                    exp_branch.push_back({32'd0, golden[base+6]});
                drive_instr(golden[base+2], golden[base+3], flags[0]);
                idx++;
            end
            drain_pipeline();
            compare_events("writeback", 1'b1, exp_wb, obs_wb);
            compare_events("jump", 1'b0, exp_jump, obs_jump);
            compare_events("branch", 1'b0, exp_branch, obs_branch);
            exp_wb.delete();
            obs_wb.delete();
            exp_jump.delete();
            obs_jump.delete();
            exp_branch.delete();
            obs_branch.delete();
            n_tests++;
            if (errors == errors_before)
            begin
                $display("test %s: ok", cur_test);
            end
            else
            begin
                n_failed++;
                $display("test %s: failed", cur_test);
            end
        end

        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 n_tests, n_failed, checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    initial
    begin
        wait (limit > 0 && cycles >= limit);
        $display("Timeout after %0d cycles, the DUT did not deliver the expected pulses", limit);
        $display("sim failed");
        $finish;
    end

endmodule

/* test/core_golden.txt */
// Columns: test flags pc word wb_reg wb_data target, one instruction per line, test 0 ends
// Flags: 1 stalls if issued right after the previous word, 2 writeback, 4 jump, 8 branch taken
01 2 00000100 24010005 01 00000005 00000000
01 2 00000104 2402FFFD 02 FFFFFFFD 00000000
01 2 00000108 00221821 03 00000002 00000000
01 2 0000010C 00222023 04 00000008 00000000
01 2 00000110 00222824 05 00000005 00000000
01 2 00000114 00223025 06 FFFFFFFD 00000000
01 2 00000118 0041382A 07 00000001 00000000
01 2 0000011C 00014100 08 00000050 00000000
01 2 00000120 3049F0F0 09 0000F0F0 00000000
01 2 00000124 342A8000 0A 00008005 00000000
01 2 00000128 3C0B1234 0B 12340000 00000000
02 2 00000200 240C0001 0C 00000001 00000000
02 2 00000204 018C6821 0D 00000002 00000000
02 2 00000208 01AC7021 0E 00000003 00000000
02 2 0000020C 01CD7023 0E 00000001 00000000
02 2 00000210 000E78C0 0F 00000008 00000000
02 2 00000214 01ED8025 10 0000000A 00000000
03 2 00000300 3C11CAFE 11 CAFE0000 00000000
03 2 00000304 3631BABE 11 CAFEBABE 00000000
03 0 00000308 AC110008 00 00000000 00000000
03 2 0000030C 8C120008 12 CAFEBABE 00000000
03 3 00000310 26530001 13 CAFEBABF 00000000
03 2 00000314 8C140008 14 CAFEBABE 00000000
03 3 00000318 0194A821 15 CAFEBABF 00000000
04 4 00400400 08100040 00 00000000 00400100
04 6 00400404 0C100080 1F 0040040C 00400200
04 2 00400408 24164000 16 00004000 00000000
04 5 0040040C 02C00008 00 00000000 00004000
04 2 00400410 24176000 17 00006000 00000000
04 7 00400414 02E0C009 18 0040041C 00006000
04 4 00400418 03E00008 00 00000000 0040040C
05 8 00000500 10210004 00 00000000 00000514
05 8 00000504 142CFFFE 00 00000000 00000500
05 0 00000508 102C0003 00 00000000 00000000
05 0 0000050C 15AD0003 00 00000000 00000000
05 2 00000510 24190005 19 00000005 00000000
05 8 00000514 13210008 00 00000000 00000538
06 2 00000600 24000055 00 00000055 00000000
06 2 00000604 0000D021 1A 00000000 00000000
06 2 00000608 3C00FFFF 00 FFFF0000 00000000
06 2 0000060C 0001D821 1B 00000005 00000000
00 0 00000000 00000000 00 00000000 00000000

/* sim.f */
src/isa_pkg.sv
src/pipe_pkg.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/core_top.sv
test/clk_gen.sv
test/tb_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the core testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_core -f sim.f \
    && ./obj_dir/Vtb_core > sim.log 2>&1
grep -q "^sim passed$" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
